//--- compile.f
design/cpu_pkg.sv
design/register_bank.sv
design/decode_stage.sv
design/execute_stage.sv
design/apb_debug_unit.sv
design/mini_cpu_top.sv
bench/tb_mini_cpu.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mini_cpu
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Finished with no errors
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
              --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_mini_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mini_cpu;

    import cpu_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int N_INSTR     = 80;   // Upper bound on instructions sent
    localparam int N_APB       = 240;  // Upper bound on APB transfers
    localparam int APB_CYCLES  = 6;    // Setup, access, wait state and idle with margin
    localparam int WAIT_LIMIT  = 20;
    localparam int WATCHDOG_NS = (N_INSTR * 4 + N_APB * APB_CYCLES + 50) * CLK_PERIOD;

    logic        clock;
    logic        reset;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_ready;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] model [32];  // Expected architectural registers
    logic [31:0] lcg_state;
    int          retired;
    int          errors;
    int          checks;
    string       test_name;

    mini_cpu_top #(.P_NB_DATA(32), .P_NB_REG_ADDR(5)) i_dut (
        .i_clock(clock), .i_reset(reset), .i_instr_valid(instr_valid), .i_instr(instr),
        .o_instr_ready(instr_ready), .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready),
        .o_pslverr(pslverr)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Sequential semantics of one instruction
    function automatic void model_exec(input logic [31:0] word);
        logic [4:0]  dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a    = model[word[25:21]];
        b    = model[word[20:16]];
        dest = word[20:16];
        res  = '0;
        case (word[31:26])
            OP_RTYPE: begin
                dest = word[15:11];
                case (word[5:0])
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: dest = '0;
                endcase
            end
            OP_ADDI: res = a + {{16{word[15]}}, word[15:0]};
            OP_ORI:  res = a | {16'h0000, word[15:0]};
            OP_LUI:  res = {word[15:0], 16'h0000};
            default: dest = '0;
        endcase
        if (dest != '0) begin
            model[dest] = res;  // Register 0 stays zero
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, got);
        end
    endtask

    task automatic send_instr(input logic [31:0] word);
        int waited;
        waited = 0;
        @(negedge clock);
        instr_valid = 1'b1;
        instr       = word;
        @(posedge clock);
        while (!instr_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clock);
        end
        assert (instr_ready) else begin
            errors++;
            $display("%s: instruction port never became ready", test_name);
        end
        if (instr_ready) begin
            model_exec(word);
            retired++;
        end
    endtask

    task automatic stop_instr();
        @(negedge clock);
        instr_valid = 1'b0;
    endtask

    task automatic apb_xfer(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
        int waited;
        waited = 0;
        @(negedge clock);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clock);
        penable = 1'b1;
        @(posedge clock);
        while (!pready && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clock);
        end
        assert (pready) else begin
            errors++;
            $display("%s: APB access to address %h never completed", test_name, addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused_data;
        apb_xfer(1'b1, addr, data, unused_data, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, 32'd0, data, err);
    endtask

    // Halt, wait for drain, compare COUNT and every register, resume
    task automatic halt_and_check();
        logic [31:0] data;
        logic        err;
        int          waited;
        waited = 0;
        apb_write(DBG_CTRL, 32'd1, err);
        check_value("CTRL write pslverr", 32'd0, {31'd0, err});
        apb_read(DBG_STATUS, data, err);
        while (!data[0] && waited < WAIT_LIMIT) begin
            waited++;
            apb_read(DBG_STATUS, data, err);
        end
        assert (data[0]) else begin
            errors++;
            $display("%s: STATUS never showed the pipeline halted", test_name);
        end
        check_value("instr_ready while halted", 32'd0, {31'd0, instr_ready});
        apb_read(DBG_COUNT, data, err);
        check_value("COUNT", 32'(retired), data);
        for (int r = 0; r < 32; r++) begin
            apb_read(DBG_REG_BASE + 8'(4 * r), data, err);
            check_value($sformatf("r%0d", r), model[r], data);
            check_value($sformatf("r%0d pslverr", r), 32'd0, {31'd0, err});
        end
        apb_write(DBG_CTRL, 32'd0, err);
    endtask

    task automatic reset_state_readback();
        test_name = "reset_state";
        halt_and_check();
    endtask

    task automatic random_itype_load();
        logic [31:0] rnd;
        logic [4:0]  rt;
        test_name = "itype_random";
        for (int k = 0; k < 12; k++) begin
            rnd = lcg_next();
            rt  = (rnd[31:27] == 5'd0) ? 5'd1 : rnd[31:27];
            case (k % 3)
                0:       send_instr(enc_i(OP_ADDI, rt, 5'd0, rnd[15:0]));
                1:       send_instr(enc_i(OP_ORI, rt, 5'd0, rnd[15:0]));
                default: send_instr(enc_i(OP_LUI, rt, 5'd0, rnd[15:0]));
            endcase
        end
        stop_instr();
        halt_and_check();
    endtask

    task automatic rtype_alu_ops();
        test_name = "rtype_ops";
        send_instr(enc_i(OP_ADDI, 5'd1, 5'd0, 16'd5));
        send_instr(enc_i(OP_ADDI, 5'd2, 5'd0, 16'hfffd));   // -3
        send_instr(enc_i(OP_LUI, 5'd3, 5'd0, 16'h8000));    // Most negative value
        send_instr(enc_i(OP_ORI, 5'd4, 5'd0, 16'hf0f0));
        send_instr(enc_r(FN_ADD, 5'd5, 5'd1, 5'd2));
        send_instr(enc_r(FN_SUB, 5'd6, 5'd0, 5'd1));        // Wraps below zero
        send_instr(enc_r(FN_SUB, 5'd7, 5'd3, 5'd1));        // Wraps to positive
        send_instr(enc_r(FN_AND, 5'd8, 5'd4, 5'd2));
        send_instr(enc_r(FN_OR, 5'd9, 5'd3, 5'd4));
        send_instr(enc_r(FN_XOR, 5'd10, 5'd4, 5'd2));
        send_instr(enc_r(FN_SLT, 5'd11, 5'd2, 5'd1));       // Negative below positive
        send_instr(enc_r(FN_SLT, 5'd12, 5'd1, 5'd2));
        send_instr(enc_r(FN_SLT, 5'd13, 5'd3, 5'd4));
        send_instr(enc_r(FN_SLT, 5'd14, 5'd1, 5'd1));
        stop_instr();
        halt_and_check();
    endtask

    task automatic dependent_chains();
        logic [31:0] rnd;
        logic [31:0] word;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        test_name = "hazard_chains";
        send_instr(enc_i(OP_ADDI, 5'd15, 5'd0, 16'd1));
        send_instr(enc_i(OP_ADDI, 5'd15, 5'd15, 16'd2));    // Distance 1
        send_instr(enc_r(FN_ADD, 5'd16, 5'd15, 5'd15));
        send_instr(enc_i(OP_ADDI, 5'd17, 5'd0, 16'd100));
        send_instr(enc_i(OP_ORI, 5'd18, 5'd0, 16'h0003));
        send_instr(enc_r(FN_SUB, 5'd19, 5'd17, 5'd18));     // Distances 2 and 1
        for (int k = 0; k < 4; k++) begin
            rnd = lcg_next();
            send_instr(enc_i(OP_LUI, 5'd20 + 5'(k), 5'd0, rnd[31:16]));
        end
        for (int k = 0; k < 16; k++) begin
            rnd = lcg_next();
            rd  = 5'd20 + 5'(rnd[31:30]);
            rs  = 5'd20 + 5'(rnd[29:28]);
            rt  = 5'd20 + 5'(rnd[27:26]);
            case (rnd[25:23])
                3'd0:    word = enc_r(FN_ADD, rd, rs, rt);
                3'd1:    word = enc_r(FN_SUB, rd, rs, rt);
                3'd2:    word = enc_r(FN_AND, rd, rs, rt);
                3'd3:    word = enc_r(FN_OR, rd, rs, rt);
                3'd4:    word = enc_r(FN_XOR, rd, rs, rt);
                3'd5:    word = enc_r(FN_SLT, rd, rs, rt);
                3'd6:    word = enc_i(OP_ADDI, rd, rs, rnd[15:0]);
                default: word = enc_i(OP_ORI, rd, rs, rnd[15:0]);
            endcase
            send_instr(word);
        end
        stop_instr();
        halt_and_check();
    endtask

    task automatic register_zero_writes();
        test_name = "reg_zero";
        send_instr(enc_i(OP_ADDI, 5'd0, 5'd0, 16'h1234));
        send_instr(enc_r(FN_ADD, 5'd24, 5'd0, 5'd0));       // Must not see the write
        send_instr(enc_i(OP_LUI, 5'd0, 5'd0, 16'hffff));
        send_instr(enc_r(FN_OR, 5'd0, 5'd1, 5'd2));
        send_instr(enc_i(OP_ORI, 5'd25, 5'd0, 16'h0000));
        stop_instr();
        halt_and_check();
    endtask

    task automatic debug_port_errors();
        logic [31:0] data;
        logic        err;
        test_name = "apb_errors";
        apb_write(DBG_STATUS, 32'd1, err);
        check_value("STATUS write pslverr", 32'd1, {31'd0, err});
        apb_read(8'h40, data, err);
        check_value("unmapped read pslverr", 32'd1, {31'd0, err});
        apb_read(DBG_REG_BASE + 8'd8, data, err);           // Pipeline still running
        check_value("running register read pslverr", 32'd1, {31'd0, err});
        apb_write(DBG_CTRL, 32'd1, err);
        @(negedge clock);
        check_value("instr_ready while halted", 32'd0, {31'd0, instr_ready});
        apb_read(DBG_COUNT, data, err);
        check_value("COUNT", 32'(retired), data);
        apb_write(DBG_REG_BASE, 32'h0000_beef, err);
        check_value("register write pslverr", 32'd1, {31'd0, err});
        apb_write(DBG_CTRL, 32'd0, err);
    endtask

    initial begin
        lcg_state   = 32'h766f;
        errors      = 0;
        checks      = 0;
        retired     = 0;
        test_name   = "reset";
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        repeat (5) @(posedge clock);
        check_value("instr_ready in reset", 32'd0, {31'd0, instr_ready});
        @(negedge clock);
        reset = 1'b0;
        @(posedge clock);
        check_value("idle pready", 32'd0, {31'd0, pready});
        check_value("idle pslverr", 32'd0, {31'd0, pslverr});
        reset_state_readback();
        random_itype_load();
        rtype_alu_ops();
        dependent_chains();
        register_zero_writes();
        debug_port_errors();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns in test %s, errors so far: %0d",
                 WATCHDOG_NS, test_name, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/mini_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mini_cpu_top #(
    parameter int P_NB_DATA     = cpu_pkg::NB_DATA,
    parameter int P_NB_REG_ADDR = cpu_pkg::NB_REG_ADDR
) (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_instr_valid,
    input  logic [31:0]          i_instr,
    output logic                 o_instr_ready,
    input  logic                 i_psel,
    input  logic                 i_penable,
    input  logic                 i_pwrite,
    input  logic [7:0]           i_paddr,
    input  logic [P_NB_DATA-1:0] i_pwdata,
    output logic [P_NB_DATA-1:0] o_prdata,
    output logic                 o_pready,
    output logic                 o_pslverr
);

    import cpu_pkg::*;

    logic [P_NB_REG_ADDR-1:0] rd_addr_a;
    logic [P_NB_REG_ADDR-1:0] rd_addr_b;
    logic [P_NB_DATA-1:0]     rd_data_a;
    logic [P_NB_DATA-1:0]     rd_data_b;
    logic                     dec_valid;
    alu_op_e                  dec_alu_op;
    logic [P_NB_REG_ADDR-1:0] dec_dest;
    logic                     dec_write;
    logic                     dec_use_imm;
    logic [P_NB_DATA-1:0]     dec_imm;
    logic [P_NB_REG_ADDR-1:0] dec_src_a;
    logic [P_NB_REG_ADDR-1:0] dec_src_b;
    logic                     wb_write;
    logic [P_NB_REG_ADDR-1:0] wb_addr;
    logic [P_NB_DATA-1:0]     wb_data;
    logic                     halt_req;
    logic                     pipe_empty;
    logic                     exec_busy;
    logic                     retire;
    logic                     dbg_read;
    logic [P_NB_REG_ADDR-1:0] dbg_addr;

    decode_stage #(.P_NB_DATA(P_NB_DATA), .P_NB_REG_ADDR(P_NB_REG_ADDR)) u_decode (
        .i_clock(i_clock), .i_reset(i_reset), .i_instr_valid(i_instr_valid),
        .i_instr(i_instr), .i_halt(halt_req), .o_instr_ready(o_instr_ready),
        .o_read_addr_a(rd_addr_a), .o_read_addr_b(rd_addr_b), .o_valid(dec_valid),
        .o_alu_op(dec_alu_op), .o_dest(dec_dest), .o_write(dec_write),
        .o_use_imm(dec_use_imm), .o_imm(dec_imm), .o_src_a(dec_src_a),
        .o_src_b(dec_src_b), .o_empty(pipe_empty)
    );

    execute_stage #(.P_NB_DATA(P_NB_DATA), .P_NB_REG_ADDR(P_NB_REG_ADDR)) u_execute (
        .i_clock(i_clock), .i_reset(i_reset), .i_valid(dec_valid), .i_alu_op(dec_alu_op),
        .i_dest(dec_dest), .i_write(dec_write), .i_use_imm(dec_use_imm), .i_imm(dec_imm),
        .i_src_a(dec_src_a), .i_src_b(dec_src_b), .i_data_a(rd_data_a),
        .i_data_b(rd_data_b), .o_wb_write(wb_write), .o_wb_addr(wb_addr),
        .o_wb_data(wb_data), .o_busy(exec_busy), .o_retire(retire)
    );

    register_bank #(.P_NB_DATA(P_NB_DATA), .P_NB_REG_ADDR(P_NB_REG_ADDR)) u_bank (
        .i_clock(i_clock), .i_reset(i_reset), .i_write(wb_write), .i_write_addr(wb_addr),
        .i_write_data(wb_data), .i_read_addr_a(rd_addr_a), .i_read_addr_b(rd_addr_b),
        .i_dbg_read(dbg_read), .i_dbg_addr(dbg_addr), .o_data_a(rd_data_a),
        .o_data_b(rd_data_b)
    );

    apb_debug_unit #(.P_NB_DATA(P_NB_DATA), .P_NB_REG_ADDR(P_NB_REG_ADDR)) u_debug (
        .i_clock(i_clock), .i_reset(i_reset), .i_psel(i_psel), .i_penable(i_penable),
        .i_pwrite(i_pwrite), .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .i_pipe_empty(pipe_empty), .i_exec_busy(exec_busy), .i_retire(retire),
        .i_reg_data(rd_data_a), .o_prdata(o_prdata), .o_pready(o_pready),
        .o_pslverr(o_pslverr), .o_halt(halt_req), .o_dbg_read(dbg_read),
        .o_dbg_addr(dbg_addr)
    );

endmodule

`default_nettype wire

//--- design/apb_debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module apb_debug_unit #(
    parameter int P_NB_DATA     = cpu_pkg::NB_DATA,
    parameter int P_NB_REG_ADDR = cpu_pkg::NB_REG_ADDR
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_psel,
    input  logic                     i_penable,
    input  logic                     i_pwrite,
    input  logic [7:0]               i_paddr,
    input  logic [P_NB_DATA-1:0]     i_pwdata,
    input  logic                     i_pipe_empty,
    input  logic                     i_exec_busy,
    input  logic                     i_retire,
    input  logic [P_NB_DATA-1:0]     i_reg_data,    // Bank port A
    output logic [P_NB_DATA-1:0]     o_prdata,
    output logic                     o_pready,
    output logic                     o_pslverr,
    output logic                     o_halt,
    output logic                     o_dbg_read,
    output logic [P_NB_REG_ADDR-1:0] o_dbg_addr
);

    import cpu_pkg::*;

    localparam int unsigned REG_COUNT = 1 << P_NB_REG_ADDR;

    logic                 access;
    logic                 halted;
    logic [7:0]           reg_offset;
    logic                 is_ctrl;
    logic                 is_status;
    logic                 is_count;
    logic                 is_reg;
    logic                 error;
    logic                 rd_wait;      // Bank data arrives next cycle
    logic [P_NB_DATA-1:0] retire_count;

    assign access     = i_psel && i_penable;
    assign halted     = o_halt && i_pipe_empty && !i_exec_busy;
    assign reg_offset = i_paddr - DBG_REG_BASE;

    assign is_ctrl   = i_paddr == DBG_CTRL;
    assign is_status = i_paddr == DBG_STATUS;
    assign is_count  = i_paddr == DBG_COUNT;
    assign is_reg    = (i_paddr >= DBG_REG_BASE) && (reg_offset[1:0] == 2'b00)
                       && (32'(reg_offset[7:2]) < REG_COUNT);

    assign error = (i_pwrite && !is_ctrl)
                   || !(is_ctrl || is_status || is_count || is_reg)
                   || (is_reg && !halted);

    assign o_dbg_read = access && is_reg && !i_pwrite && halted;
    assign o_dbg_addr = reg_offset[2 +: P_NB_REG_ADDR];

    assign o_pready  = access && (!o_dbg_read || rd_wait);
    assign o_pslverr = o_pready && error;

    always_comb begin
        o_prdata = '0;
        if (o_pready && !i_pwrite) begin
            if (is_ctrl) begin
                o_prdata[0] = o_halt;
            end else if (is_status) begin
                o_prdata[1:0] = {o_halt, halted};  // Bit 0 halted and drained
            end else if (is_count) begin
                o_prdata = retire_count;
            end else if (is_reg && halted) begin
                o_prdata = i_reg_data;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_halt       <= 1'b0;
            rd_wait      <= 1'b0;
            retire_count <= '0;
        end else begin
            if (access && i_pwrite && is_ctrl) begin
                o_halt <= i_pwdata[0];
            end
            rd_wait <= o_dbg_read && !rd_wait;
            if (i_retire) begin
                retire_count <= retire_count + 1'b1;
            end
        end
    end

    // A register read completes only after a cycle of bank latency
    a_pready_in_access: assert property (@(posedge i_clock) disable iff (i_reset)
        o_pready |-> (i_psel && i_penable && (!o_dbg_read || $past(o_dbg_read))))
        else $error("pready outside an APB access phase or before register data");

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
    parameter int P_NB_DATA     = cpu_pkg::NB_DATA,
    parameter int P_NB_REG_ADDR = cpu_pkg::NB_REG_ADDR
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_valid,
    input  cpu_pkg::alu_op_e         i_alu_op,
    input  logic [P_NB_REG_ADDR-1:0] i_dest,
    input  logic                     i_write,
    input  logic                     i_use_imm,
    input  logic [P_NB_DATA-1:0]     i_imm,
    input  logic [P_NB_REG_ADDR-1:0] i_src_a,
    input  logic [P_NB_REG_ADDR-1:0] i_src_b,
    input  logic [P_NB_DATA-1:0]     i_data_a,  // Registered bank read
    input  logic [P_NB_DATA-1:0]     i_data_b,
    output logic                     o_wb_write,
    output logic [P_NB_REG_ADDR-1:0] o_wb_addr,
    output logic [P_NB_DATA-1:0]     o_wb_data,
    output logic                     o_busy,
    output logic                     o_retire
);

    import cpu_pkg::*;

    logic                 fwd_a;
    logic                 fwd_b;
    logic [P_NB_DATA-1:0] op_a;
    logic [P_NB_DATA-1:0] reg_b;
    logic [P_NB_DATA-1:0] op_b;
    logic [P_NB_DATA-1:0] result;
    logic                 res_valid;

    // Previous result is not in the bank yet
    assign fwd_a = o_wb_write && (o_wb_addr == i_src_a);
    assign fwd_b = o_wb_write && (o_wb_addr == i_src_b);

    assign op_a  = fwd_a ? o_wb_data : i_data_a;
    assign reg_b = fwd_b ? o_wb_data : i_data_b;
    assign op_b  = i_use_imm ? i_imm : reg_b;

    always_comb begin
        case (i_alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLT: result = {{(P_NB_DATA-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_LUI: result = op_b << 16;     // Upper half from immediate
            default: result = '0;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            res_valid  <= 1'b0;
            o_wb_write <= 1'b0;
        end else begin
            res_valid  <= i_valid;
            o_wb_write <= i_valid && i_write;
        end
    end

    // Result register feeds writeback
    always_ff @(posedge i_clock) begin
        if (i_valid) begin
            o_wb_addr <= i_dest;
            o_wb_data <= result;
        end
    end

    assign o_busy   = res_valid;
    assign o_retire = res_valid;   // One pulse per completed instruction

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int P_NB_DATA     = cpu_pkg::NB_DATA,
    parameter int P_NB_REG_ADDR = cpu_pkg::NB_REG_ADDR
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_instr_valid,
    input  cpu_pkg::instr_t          i_instr,
    input  logic                     i_halt,
    output logic                     o_instr_ready,
    output logic [P_NB_REG_ADDR-1:0] o_read_addr_a,
    output logic [P_NB_REG_ADDR-1:0] o_read_addr_b,
    output logic                     o_valid,
    output cpu_pkg::alu_op_e         o_alu_op,
    output logic [P_NB_REG_ADDR-1:0] o_dest,
    output logic                     o_write,
    output logic                     o_use_imm,
    output logic [P_NB_DATA-1:0]     o_imm,
    output logic [P_NB_REG_ADDR-1:0] o_src_a,
    output logic [P_NB_REG_ADDR-1:0] o_src_b,
    output logic                     o_empty
);

    import cpu_pkg::*;

    logic                     running;     // Low until the first edge out of reset
    logic                     accept;
    logic                     known;
    logic                     zero_ext;
    alu_op_e                  alu_op;
    logic [P_NB_REG_ADDR-1:0] dest;
    logic                     use_imm;
    logic [P_NB_DATA-1:0]     imm_ext;

    assign o_instr_ready = running && !i_halt;
    assign accept        = i_instr_valid && o_instr_ready;

    // rs and rt sit at the same place in both views
    assign o_read_addr_a = i_instr.r_view.rs;
    assign o_read_addr_b = i_instr.r_view.rt;

    always_comb begin
        known    = 1'b1;
        alu_op   = ALU_ADD;
        dest     = i_instr.i_view.rt;
        use_imm  = 1'b1;
        zero_ext = 1'b0;
        case (i_instr.r_view.opcode)
            OP_RTYPE: begin
                dest    = i_instr.r_view.rd;
                use_imm = 1'b0;
                case (i_instr.r_view.funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: known  = 1'b0;
                endcase
            end
            OP_ADDI: alu_op = ALU_ADD;
            OP_ORI: begin
                alu_op   = ALU_OR;
                zero_ext = 1'b1;
            end
            OP_LUI: begin
                alu_op   = ALU_LUI;
                zero_ext = 1'b1;
            end
            default: known = 1'b0; // Dropped as a bubble
        endcase
    end

    assign imm_ext = zero_ext ? {{(P_NB_DATA-16){1'b0}}, i_instr.i_view.imm}
                              : {{(P_NB_DATA-16){i_instr.i_view.imm[15]}}, i_instr.i_view.imm};

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            running <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            o_valid <= accept && known;
        end
    end

    // Decoded fields, only meaningful while o_valid
    always_ff @(posedge i_clock) begin
        if (accept) begin
            o_alu_op  <= alu_op;
            o_dest    <= dest;
            o_write   <= known && (dest != '0);
            o_use_imm <= use_imm;
            o_imm     <= imm_ext;
            o_src_a   <= i_instr.r_view.rs;
            o_src_b   <= i_instr.r_view.rt;
        end
    end

    assign o_empty = !o_valid;

    a_no_write_r0: assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_valid && o_write && (o_dest == '0)))
        else $error("decode issued a write to register 0");

endmodule

`default_nettype wire

//--- design/register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module register_bank #(
    parameter int P_NB_DATA     = cpu_pkg::NB_DATA,
    parameter int P_NB_REG_ADDR = cpu_pkg::NB_REG_ADDR
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_write,         // Writeback strobe
    input  logic [P_NB_REG_ADDR-1:0] i_write_addr,
    input  logic [P_NB_DATA-1:0]     i_write_data,
    input  logic [P_NB_REG_ADDR-1:0] i_read_addr_a,
    input  logic [P_NB_REG_ADDR-1:0] i_read_addr_b,
    input  logic                     i_dbg_read,      // Debug owns port A
    input  logic [P_NB_REG_ADDR-1:0] i_dbg_addr,
    output logic [P_NB_DATA-1:0]     o_data_a,
    output logic [P_NB_DATA-1:0]     o_data_b
);

    localparam int DEPTH = 1 << P_NB_REG_ADDR;

    logic [P_NB_DATA-1:0]     regs [DEPTH];
    logic [P_NB_REG_ADDR-1:0] addr_a;
    logic                     write_ok;
    logic                     bypass_a;
    logic                     bypass_b;

    assign addr_a   = i_dbg_read ? i_dbg_addr : i_read_addr_a;
    assign write_ok = i_write && (i_write_addr != '0); // Register 0 is never written

    // Same-cycle write forwarded to the read ports
    assign bypass_a = write_ok && (i_write_addr == addr_a);
    assign bypass_b = write_ok && (i_write_addr == i_read_addr_b);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (write_ok) begin
            regs[i_write_addr] <= i_write_data;
        end
    end

    // Registered read ports
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_data_a <= '0;
            o_data_b <= '0;
        end else begin
            o_data_a <= bypass_a ? i_write_data : regs[addr_a];
            o_data_b <= bypass_b ? i_write_data : regs[i_read_addr_b];
        end
    end

    // Register 0 reads zero through storage and bypass
    property p_reg_zero_stays;
        @(posedge i_clock) disable iff (i_reset)
            (addr_a == '0) |=> (o_data_a == '0);
    endproperty

    a_reg_zero_stays: assert property (p_reg_zero_stays)
        else $error("register 0 read back a nonzero value");

endmodule

`default_nettype wire

//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int NB_DATA     = 32;
    localparam int NB_REG_ADDR = 5;

    // MIPS-style opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;

    // R-type function field
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [NB_REG_ADDR-1:0] rs;
        logic [NB_REG_ADDR-1:0] rt;
        logic [NB_REG_ADDR-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [NB_REG_ADDR-1:0] rs;
        logic [NB_REG_ADDR-1:0] rt;
        logic [15:0]            imm;
    } i_view_t;

    // Same word, two field layouts
    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_t;

    // Debug APB byte addresses
    localparam logic [7:0] DBG_CTRL     = 8'h00;
    localparam logic [7:0] DBG_STATUS   = 8'h04;
    localparam logic [7:0] DBG_COUNT    = 8'h08;
    localparam logic [7:0] DBG_REG_BASE = 8'h80; // Register n at base + 4n

endpackage

`default_nettype wire
